// File: hdl/ltm_cfg_pkg.sv
/* Shared constants and the command word for the LTM configuration path.
   SCLK_DIV must be 2 or more. The table size is fixed by the LTM register map. */
package ltm_cfg_pkg;

  // Number of commands in the power-up table
  localparam int NUM_ENTRIES = 20;
  localparam int IDX_W = 5;
  localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_ENTRIES - 1);

  // clk cycles per half period of ltm_sclk
  localparam int SCLK_DIV = 4;
  localparam int DIV_W = $clog2(SCLK_DIV);
  localparam logic [DIV_W-1:0] DIV_LAST = DIV_W'(SCLK_DIV - 1);

  // Sequencer state codes
  localparam logic [2:0] SEQ_IDLE   = 3'd0;
  localparam logic [2:0] SEQ_SETTLE = 3'd1;
  localparam logic [2:0] SEQ_SEND   = 3'd2;
  localparam logic [2:0] SEQ_WAIT   = 3'd3;
  localparam logic [2:0] SEQ_NEXT   = 3'd4;
  localparam logic [2:0] SEQ_DONE   = 3'd5;

  // One serial command, MSB first on the wire
  // ROM fills the fields, serializer shifts the raw bits
  typedef union packed {
    logic [15:0] raw;
    struct packed {
      logic [5:0] reg_addr;
      // Read/write, always 0 for write
      logic       rw;
      // Turnaround, always 0
      logic       ta;
      logic [7:0] data;
    } f;
  } ltm_cmd_u;

endpackage

// File: hdl/ltm_init_rom.sv
/* LTM power-up register table, 20 fixed entries, write commands only.
   state_reg trails rom_address by one step per cycle; output follows state_reg. */
`timescale 1ns/100ps

module ltm_init_rom (
  input  logic                          clk,
  input  logic                          rst,
  input  logic [ltm_cfg_pkg::IDX_W-1:0] rom_address,
  output logic [23:0]                   rom_data
);

  logic [ltm_cfg_pkg::IDX_W-1:0] state_reg;
  logic [5:0]                    reg_addr;
  logic [7:0]                    data_byte;
  ltm_cfg_pkg::ltm_cmd_u         cmd;

  // Walk toward the requested index, one step at a time
  always_ff @(posedge clk) begin
    if (rst) begin
      state_reg <= '0;
    end else if (state_reg > ltm_cfg_pkg::LAST_IDX) begin
      // Out-of-range state recovers to the first entry
      state_reg <= '0;
    end else if (state_reg != rom_address) begin
      if (state_reg == ltm_cfg_pkg::LAST_IDX) begin
        state_reg <= '0;
      end else begin
        state_reg <= state_reg + 1'b1;
      end
    end
  end

  // Register map, address and data per entry
  always_comb begin
    case (state_reg)
      5'd0:    {reg_addr, data_byte} = {6'h02, 8'h07};
      5'd1:    {reg_addr, data_byte} = {6'h03, 8'hdf};
      5'd2:    {reg_addr, data_byte} = {6'h04, 8'h17};
      5'd3:    {reg_addr, data_byte} = {6'h11, 8'h00};
      5'd4:    {reg_addr, data_byte} = {6'h12, 8'h5b};
      5'd5:    {reg_addr, data_byte} = {6'h13, 8'hff};
      5'd6:    {reg_addr, data_byte} = {6'h14, 8'h00};
      5'd7:    {reg_addr, data_byte} = {6'h15, 8'h20};
      5'd8:    {reg_addr, data_byte} = {6'h16, 8'h40};
      5'd9:    {reg_addr, data_byte} = {6'h17, 8'h80};
      5'd10:   {reg_addr, data_byte} = {6'h18, 8'h00};
      5'd11:   {reg_addr, data_byte} = {6'h19, 8'h80};
      5'd12:   {reg_addr, data_byte} = {6'h1a, 8'h00};
      5'd13:   {reg_addr, data_byte} = {6'h1b, 8'h00};
      5'd14:   {reg_addr, data_byte} = {6'h1c, 8'h80};
      5'd15:   {reg_addr, data_byte} = {6'h1d, 8'hc0};
      5'd16:   {reg_addr, data_byte} = {6'h1e, 8'he0};
      5'd17:   {reg_addr, data_byte} = {6'h1f, 8'hff};
      5'd18:   {reg_addr, data_byte} = {6'h20, 8'hd2};
      5'd19:   {reg_addr, data_byte} = {6'h21, 8'hd2};
      default: {reg_addr, data_byte} = {6'h00, 8'h00};
    endcase
  end

  // Build the command in field view, write with zero turnaround
  always_comb begin
    cmd.f.reg_addr = reg_addr;
    cmd.f.rw       = 1'b0;
    cmd.f.ta       = 1'b0;
    cmd.f.data     = data_byte;
  end

  // Upper byte unused by the LTM
  assign rom_data = {8'h00, cmd.raw};

endmodule

// File: hdl/ltm_init_sequencer.sv
/* Walks the 20-entry table once per init_req and hands words to the serializer.
   Both sides are four-phase; init_ack holds until init_req is seen low. */
`timescale 1ns/100ps

module ltm_init_sequencer (
  input  logic                          clk,
  input  logic                          rst,
  input  logic                          init_req,
  output logic                          init_ack,
  output logic [ltm_cfg_pkg::IDX_W-1:0] rom_address,
  input  logic [23:0]                   rom_data,
  output logic                          cmd_req,
  output ltm_cfg_pkg::ltm_cmd_u         cmd_word,
  input  logic                          cmd_ack
);

  logic [2:0]                    state;
  // Words acknowledged by the serializer in this run
  logic [ltm_cfg_pkg::IDX_W-1:0] sent_cnt;

  always_ff @(posedge clk) begin
    if (rst) begin
      state       <= ltm_cfg_pkg::SEQ_IDLE;
      init_ack    <= 1'b0;
      cmd_req     <= 1'b0;
      rom_address <= '0;
      sent_cnt    <= '0;
    end else begin
      case (state)
        ltm_cfg_pkg::SEQ_IDLE: begin
          // ROM already sits at entry 0 here
          if (init_req) begin
            state <= ltm_cfg_pkg::SEQ_SETTLE;
          end
        end
        ltm_cfg_pkg::SEQ_SETTLE: begin
          // One cycle for the ROM to reach rom_address
          state <= ltm_cfg_pkg::SEQ_SEND;
        end
        ltm_cfg_pkg::SEQ_SEND: begin
          if (!cmd_req) begin
            cmd_req <= 1'b1;
          end else if (cmd_ack) begin
            cmd_req <= 1'b0;
            state   <= ltm_cfg_pkg::SEQ_WAIT;
          end
        end
        ltm_cfg_pkg::SEQ_WAIT: begin
          // Return-to-zero of the command handshake
          if (!cmd_ack) begin
            sent_cnt <= sent_cnt + 1'b1;
            state    <= ltm_cfg_pkg::SEQ_NEXT;
          end
        end
        ltm_cfg_pkg::SEQ_NEXT: begin
          if (int'(sent_cnt) == ltm_cfg_pkg::NUM_ENTRIES) begin
            // Wrap for the next run, ROM follows 19 to 0
            rom_address <= '0;
            init_ack    <= 1'b1;
            state       <= ltm_cfg_pkg::SEQ_DONE;
          end else begin
            rom_address <= rom_address + 1'b1;
            state       <= ltm_cfg_pkg::SEQ_SETTLE;
          end
        end
        ltm_cfg_pkg::SEQ_DONE: begin
          // Stall here while the requester holds init_req
          if (!init_req) begin
            init_ack <= 1'b0;
            sent_cnt <= '0;
            state    <= ltm_cfg_pkg::SEQ_IDLE;
          end
        end
        default: begin
          state <= ltm_cfg_pkg::SEQ_IDLE;
        end
      endcase
    end
  end

  // Word captured as cmd_req rises, stable until it falls
  always_ff @(posedge clk) begin
    if (state == ltm_cfg_pkg::SEQ_SEND && !cmd_req) begin
      cmd_word.raw <= rom_data[15:0];
    end
  end

endmodule

// File: hdl/ltm_spi_serializer.sv
/* Three-wire write-only serializer, 16 bits MSB first, sclk idles high.
   cmd_word must stay stable while cmd_req is high. */
`timescale 1ns/100ps

module ltm_spi_serializer (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  cmd_req,
  input  ltm_cfg_pkg::ltm_cmd_u cmd_word,
  output logic                  cmd_ack,
  output logic                  ltm_sclk,
  output logic                  ltm_scen,
  output logic                  ltm_sda
);

  logic                          busy;
  // Enable released, ack pending
  logic                          frame_done;
  logic [ltm_cfg_pkg::DIV_W-1:0] div_cnt;
  // Bits already driven on sda
  logic [4:0]                    bit_cnt;
  logic [15:0]                   shift_reg;
  logic                          start;
  logic                          half_tick;

  assign start     = cmd_req && !busy && !frame_done && !cmd_ack;
  assign half_tick = busy && (div_cnt == ltm_cfg_pkg::DIV_LAST);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy       <= 1'b0;
      frame_done <= 1'b0;
      cmd_ack    <= 1'b0;
      div_cnt    <= '0;
      bit_cnt    <= '0;
      ltm_sclk   <= 1'b1;
      ltm_scen   <= 1'b1;
      ltm_sda    <= 1'b0;
    end else begin
      if (start) begin
        // Enable first, sclk falls on the next cycle
        busy     <= 1'b1;
        ltm_scen <= 1'b0;
        bit_cnt  <= '0;
        div_cnt  <= ltm_cfg_pkg::DIV_LAST;
      end else if (half_tick) begin
        div_cnt <= '0;
        if (!ltm_sclk) begin
          // LTM samples on this rise
          ltm_sclk <= 1'b1;
        end else if (bit_cnt == 5'd16) begin
          // Last high phase over, close the frame
          busy       <= 1'b0;
          ltm_scen   <= 1'b1;
          frame_done <= 1'b1;
        end else begin
          ltm_sclk <= 1'b0;
          ltm_sda  <= shift_reg[15];
          bit_cnt  <= bit_cnt + 1'b1;
        end
      end else if (busy) begin
        div_cnt <= div_cnt + 1'b1;
      end

      // Ack one cycle after release, drop once cmd_req is low
      if (frame_done) begin
        frame_done <= 1'b0;
        cmd_ack    <= 1'b1;
      end else if (cmd_ack && !cmd_req) begin
        cmd_ack <= 1'b0;
      end
    end
  end

  // Shift on each falling edge of sclk
  always_ff @(posedge clk) begin
    if (start) begin
      shift_reg <= cmd_word.raw;
    end else if (half_tick && ltm_sclk && bit_cnt != 5'd16) begin
      shift_reg <= {shift_reg[14:0], 1'b0};
    end
  end

endmodule

// File: hdl/ltm_config_top.sv
/* LTM power-up configuration, table ROM, sequencer and three-wire serializer.
   init_req/init_ack is four-phase; init_ack marks the end of all 20 writes. */
`timescale 1ns/100ps

module ltm_config_top (
  input  logic clk,
  input  logic rst,
  input  logic init_req,
  output logic init_ack,
  output logic ltm_sclk,
  output logic ltm_scen,
  output logic ltm_sda
);

  logic [ltm_cfg_pkg::IDX_W-1:0] rom_address;
  logic [23:0]                   rom_data;
  logic                          cmd_req;
  logic                          cmd_ack;
  ltm_cfg_pkg::ltm_cmd_u         cmd_word;

  ltm_init_rom rom_i (
    .clk         (clk),
    .rst         (rst),
    .rom_address (rom_address),
    .rom_data    (rom_data)
  );

  ltm_init_sequencer seq_i (
    .clk         (clk),
    .rst         (rst),
    .init_req    (init_req),
    .init_ack    (init_ack),
    .rom_address (rom_address),
    .rom_data    (rom_data),
    .cmd_req     (cmd_req),
    .cmd_word    (cmd_word),
    .cmd_ack     (cmd_ack)
  );

  ltm_spi_serializer ser_i (
    .clk      (clk),
    .rst      (rst),
    .cmd_req  (cmd_req),
    .cmd_word (cmd_word),
    .cmd_ack  (cmd_ack),
    .ltm_sclk (ltm_sclk),
    .ltm_scen (ltm_scen),
    .ltm_sda  (ltm_sda)
  );

endmodule

// File: sim/ltm_init_rom_sva.sv
/* ROM index walk and table word format checks, bound into every ltm_init_rom.
   Checks are off while rst is high. */
`timescale 1ns/100ps

module ltm_init_rom_sva (
  input logic                          clk,
  input logic                          rst,
  input logic [ltm_cfg_pkg::IDX_W-1:0] rom_address,
  input logic [ltm_cfg_pkg::IDX_W-1:0] state_reg,
  input logic [23:0]                   rom_data
);

  // Index never leaves the 20-entry table
  state_in_range: assert property (@(posedge clk) disable iff (rst)
    state_reg <= ltm_cfg_pkg::LAST_IDX)
    else $error("ROM state_reg %0d is outside the table", state_reg);

  // One step per cycle at most, 19 wraps to 0
  state_step: assert property (@(posedge clk) disable iff (rst)
    1'b1 |=> (state_reg == $past(state_reg)) ||
             (state_reg == $past(state_reg) + 1'b1) ||
             ($past(state_reg) == ltm_cfg_pkg::LAST_IDX && state_reg == '0))
    else $error("ROM state_reg jumped to %0d", state_reg);

  // Holds exactly when the requested index is reached
  state_hold: assert property (@(posedge clk) disable iff (rst)
    1'b1 |=> (state_reg == $past(state_reg)) == ($past(state_reg) == $past(rom_address)))
    else $error("ROM state_reg did not follow rom_address");

  // Upper byte unused
  upper_zero: assert property (@(posedge clk) disable iff (rst)
    rom_data[23:16] == 8'h00)
    else $error("ROM upper byte is %h", rom_data[23:16]);

  // Write bit and turnaround bit always zero
  rw_ta_zero: assert property (@(posedge clk) disable iff (rst)
    rom_data[9:8] == 2'b00)
    else $error("ROM rw/ta bits are %b", rom_data[9:8]);

endmodule

bind ltm_init_rom ltm_init_rom_sva rom_sva_i (
  .clk         (clk),
  .rst         (rst),
  .rom_address (rom_address),
  .state_reg   (state_reg),
  .rom_data    (rom_data)
);

// File: sim/ltm_config_checker.sv
/* Rebuilds serial frames from the LTM pins, sampled on clk, and checks the handshake.
   Frames are numbered per run; the table restarts at index 0 after each init_ack. */
`timescale 1ns/100ps

module ltm_config_checker (
  input  logic clk,
  input  logic rst,
  input  logic init_req,
  input  logic init_ack,
  input  logic ltm_sclk,
  input  logic ltm_scen,
  input  logic ltm_sda,
  output int   error_count,
  output int   frame_count
);

  int          runs_done = 0;
  int          bit_count = 0;
  logic        in_frame = 1'b0;
  logic [15:0] frame = '0;
  logic        prev_req;
  logic        prev_ack;
  logic        prev_sclk;
  logic        prev_scen;
  logic        prev_sda;

  initial error_count = 0;
  initial frame_count = 0;

  // Write command for each table index of the LTM register map
  function automatic logic [15:0] ltm_expected_word(input int idx);
    logic [5:0] addr;
    logic [7:0] data;
    case (idx)
      0:       {addr, data} = {6'h02, 8'h07};
      1:       {addr, data} = {6'h03, 8'hdf};
      2:       {addr, data} = {6'h04, 8'h17};
      3:       {addr, data} = {6'h11, 8'h00};
      4:       {addr, data} = {6'h12, 8'h5b};
      5:       {addr, data} = {6'h13, 8'hff};
      6:       {addr, data} = {6'h14, 8'h00};
      7:       {addr, data} = {6'h15, 8'h20};
      8:       {addr, data} = {6'h16, 8'h40};
      9:       {addr, data} = {6'h17, 8'h80};
      10:      {addr, data} = {6'h18, 8'h00};
      11:      {addr, data} = {6'h19, 8'h80};
      12:      {addr, data} = {6'h1a, 8'h00};
      13:      {addr, data} = {6'h1b, 8'h00};
      14:      {addr, data} = {6'h1c, 8'h80};
      15:      {addr, data} = {6'h1d, 8'hc0};
      16:      {addr, data} = {6'h1e, 8'he0};
      17:      {addr, data} = {6'h1f, 8'hff};
      18:      {addr, data} = {6'h20, 8'hd2};
      19:      {addr, data} = {6'h21, 8'hd2};
      default: {addr, data} = {6'h00, 8'h00};
    endcase
    // Address, write bit 0, turnaround 0, data
    return {addr, 1'b0, 1'b0, data};
  endfunction

  // Pins sampled before the DUT updates them on this edge
  always @(posedge clk) begin : watch_pins
    int          idx;
    logic [15:0] expected;
    if (!rst) begin
      // Frame opens on scen falling
      if (prev_scen && !ltm_scen) begin
        in_frame  = 1'b1;
        bit_count = 0;
        frame     = '0;
      end
      // LTM side samples sda on the sclk rise
      if (in_frame && !prev_sclk && ltm_sclk) begin
        frame = {frame[14:0], ltm_sda};
        bit_count++;
      end
      // sda may only move while sclk is low, so it must match on the rise too
      if (in_frame && !ltm_scen && ltm_sclk && ltm_sda != prev_sda) begin
        $display("sda changed while sclk was high in frame %0d", frame_count);
        error_count++;
      end
      // Frame closes on scen rising
      if (in_frame && ltm_scen) begin
        in_frame = 1'b0;
        idx      = frame_count - ltm_cfg_pkg::NUM_ENTRIES * runs_done;
        expected = ltm_expected_word(idx);
        if (bit_count != 16) begin
          $display("error: frame_bits frame %0d expected 16 actual %0d",
                   frame_count, bit_count);
          error_count++;
        end
        if (idx >= ltm_cfg_pkg::NUM_ENTRIES) begin
          $display("frame %0d was sent past the end of the table", frame_count);
          error_count++;
        end else if (frame != expected) begin
          $display("error: frame_value run %0d index %0d expected %h actual %h",
                   runs_done, idx, expected, frame);
          error_count++;
        end
        if (frame[9:8] != 2'b00) begin
          $display("error: frame_format index %0d expected rw/ta 00 actual %b",
                   idx, frame[9:8]);
          error_count++;
        end
        frame_count++;
      end
      // Bus must idle with both handshake signals low
      if (!init_req && !init_ack && (!ltm_scen || !ltm_sclk)) begin
        $display("serial bus active with no request pending");
        error_count++;
      end
      if (!prev_ack && init_ack) begin
        if (!prev_req) begin
          $display("init_ack rose without init_req");
          error_count++;
        end
        runs_done++;
        if (frame_count != ltm_cfg_pkg::NUM_ENTRIES * runs_done || !ltm_scen) begin
          $display("error: handshake expected %0d frames actual %0d",
                   ltm_cfg_pkg::NUM_ENTRIES * runs_done, frame_count);
          error_count++;
        end
      end
      if (prev_ack && !init_ack && prev_req) begin
        $display("init_ack dropped while init_req was still high");
        error_count++;
      end
    end
    prev_req  = init_req;
    prev_ack  = init_ack;
    prev_sclk = ltm_sclk;
    prev_scen = ltm_scen;
    prev_sda  = ltm_sda;
  end

endmodule

// File: sim/ltm_config_tb.sv
/* Runs three init requests with random idle gaps and ack hold times, seed 70534.
   Frame and handshake checks sit in ltm_config_checker. */
`timescale 1ns/100ps

module ltm_config_tb;

  localparam int CLK_PERIOD = 100;
  localparam int NUM_RUNS = 3;
  // Serial frame plus sequencer overhead in clk cycles
  localparam int FRAME_CYCLES = 16 * 2 * ltm_cfg_pkg::SCLK_DIV + 20;
  localparam int WATCHDOG_CYCLES = NUM_RUNS * ltm_cfg_pkg::NUM_ENTRIES * FRAME_CYCLES * 2;

  logic clk;
  logic rst;
  logic init_req;
  logic init_ack;
  logic ltm_sclk;
  logic ltm_scen;
  logic ltm_sda;
  int   error_count;
  int   frame_count;
  int   total_errors;

  ltm_config_top dut_i (
    .clk      (clk),
    .rst      (rst),
    .init_req (init_req),
    .init_ack (init_ack),
    .ltm_sclk (ltm_sclk),
    .ltm_scen (ltm_scen),
    .ltm_sda  (ltm_sda)
  );

  ltm_config_checker checker_i (
    .clk         (clk),
    .rst         (rst),
    .init_req    (init_req),
    .init_ack    (init_ack),
    .ltm_sclk    (ltm_sclk),
    .ltm_scen    (ltm_scen),
    .ltm_sda     (ltm_sda),
    .error_count (error_count),
    .frame_count (frame_count)
  );

  initial clk = 1'b0;
  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge clk);
  endtask

  // One four-phase request after a random idle gap
  task automatic run_request();
    int gap;
    int hold;
    gap  = $urandom_range(50, 0);
    hold = $urandom_range(20, 0);
    wait_cycles(gap);
    init_req = 1'b1;
    while (!init_ack) @(negedge clk);
    // Ack must hold while req stays high
    wait_cycles(hold);
    init_req = 1'b0;
    while (init_ack) @(negedge clk);
  endtask

  initial begin
    void'($urandom(70534));
    rst      = 1'b1;
    init_req = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;
    repeat (NUM_RUNS) run_request();
    // Quiet tail where any stray frame would show up
    wait_cycles(FRAME_CYCLES);
    total_errors = error_count;
    if (frame_count != NUM_RUNS * ltm_cfg_pkg::NUM_ENTRIES) begin
      $display("error: frame_total expected %0d actual %0d",
               NUM_RUNS * ltm_cfg_pkg::NUM_ENTRIES, frame_count);
      total_errors++;
    end
    $display("summary: runs %0d frames %0d errors %0d", NUM_RUNS, frame_count, total_errors);
    if (total_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  // Ends a run whose handshake never completes
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("timeout: requests did not complete within %0d cycles", WATCHDOG_CYCLES);
    $display("tests failed");
    $finish;
  end

endmodule

// File: files.f
hdl/ltm_cfg_pkg.sv
hdl/ltm_init_rom.sv
hdl/ltm_init_sequencer.sv
hdl/ltm_spi_serializer.sv
hdl/ltm_config_top.sv
sim/ltm_init_rom_sva.sv
sim/ltm_config_checker.sv
sim/ltm_config_tb.sv

// File: Bender.yml
package:
  name: ltm_config

sources:
  - files:
      - hdl/ltm_cfg_pkg.sv
      - hdl/ltm_init_rom.sv
      - hdl/ltm_init_sequencer.sv
      - hdl/ltm_spi_serializer.sv
      - hdl/ltm_config_top.sv
  - target: simulation
    files:
      - sim/ltm_init_rom_sva.sv
      - sim/ltm_config_checker.sv
      - sim/ltm_config_tb.sv
